/* source/game_pkg.sv */
package game_pkg;

  // game flow states
  typedef enum logic [1:0] {
    START,
    PLAY,
    OVER
  } game_state_t;

  // dragon pose handed to the renderer
  typedef enum logic [1:0] {
    RUN,
    JUMP,
    DUCK,
    DEAD
  } action_t;

  // keyboard scan codes as sampled once per frame
  localparam logic [7:0] key_enter = 8'h0D;
  localparam logic [7:0] key_space = 8'h20;
  localparam logic [7:0] key_down  = 8'h26;

endpackage

/* source/geometry_pkg.sv */
package geometry_pkg;

  // signed screen coordinate, also carries vertical velocity
  typedef logic signed [11:0] coord_t;

  // dragon column is the sprite centre
  localparam coord_t dragon_x = 12'sd120;
  localparam coord_t dragon_w = 12'sd88;
  localparam coord_t dragon_h = 12'sd94;

  // pterosaur sprite size
  localparam coord_t ptero_w = 12'sd92;
  localparam coord_t ptero_h = 12'sd80;

endpackage

/* source/game_fsm.sv */
`timescale 1ns/100ps

module game_fsm
  import game_pkg::*;
(
  input  logic        frame_clk,
  input  logic        rst_n,
  input  logic [7:0]  keycode,
  input  logic        dead,
  output game_state_t state
);

  game_state_t next_state;

  always_comb
  begin
    next_state = state;
    // enter restarts from anywhere
    if (keycode == key_enter)
    begin
      next_state = START;
    end
    else
    begin
      case (state)
        START:
          if (keycode == key_space)
            next_state = PLAY;
        PLAY:
          if (dead)
            next_state = OVER;
        OVER:
          next_state = OVER;
        default:
          next_state = START;
      endcase
    end
  end

  always_ff @(posedge frame_clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= START;
    else
      state <= next_state;
  end

endmodule

/* source/dragon_motion.sv */
`timescale 1ns/100ps

module dragon_motion
  import game_pkg::*;
  import geometry_pkg::*;
#(
  parameter int ground_level = 412,
  parameter int gravity      = 2,
  parameter int short_jump   = 10,
  parameter int long_jump    = 20,
  parameter int charge_limit = 30
) (
  input  logic        frame_clk,
  input  logic        rst_n,
  input  logic [7:0]  keycode,
  input  game_state_t state,
  input  logic        dead,
  output coord_t      dragon_y,
  output logic        duck,
  output action_t     action
);

  localparam int charge_max = 2 * charge_limit;
  localparam int charge_w   = $clog2(charge_max + 2);

  localparam coord_t ground_y = coord_t'(ground_level);
  localparam coord_t grav     = coord_t'(gravity);
  localparam coord_t short_v  = coord_t'(short_jump);
  localparam coord_t long_v   = coord_t'(long_jump);

  logic [charge_w-1:0] charge;
  coord_t              velocity;
  coord_t              launch_vel;
  coord_t              fall_y;
  coord_t              next_y;
  logic                space_held;
  logic                on_ground;
  logic                space_release;
  logic                land;

  always_comb
  begin
    space_held    = (keycode == key_space);
    on_ground     = (dragon_y == ground_y);
    space_release = !space_held && (charge != '0);

    // take-off replaces velocity on the release frame
    launch_vel = velocity;
    if (space_release && on_ground)
    begin
      if (charge < charge_w'(charge_limit))
        launch_vel = -short_v;
      else
        launch_vel = -long_v;
    end

    // clamp to the ground once the next step would reach it
    fall_y = dragon_y + launch_vel;
    land   = (fall_y >= ground_y);
    next_y = land ? ground_y : fall_y;
  end

  // only ducks while standing
  assign duck = (keycode == key_down) && on_ground;

  always_ff @(posedge frame_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      charge   <= '0;
      velocity <= '0;
      dragon_y <= ground_y;
      action   <= RUN;
    end
    else if (state == START)
    begin
      // title screen parks the dragon on the ground
      charge   <= '0;
      velocity <= '0;
      dragon_y <= ground_y;
      action   <= RUN;
    end
    else if (state == PLAY)
    begin
      if (space_held && on_ground)
      begin
        if (charge < charge_w'(charge_max))
          charge <= charge + 1'b1;
      end
      else if (space_release)
      begin
        charge <= '0;
      end

      dragon_y <= next_y;
      velocity <= land ? coord_t'(0) : launch_vel + grav;

      if (dead)
        action <= DEAD;
      else if (next_y != ground_y)
        action <= JUMP;
      else if (keycode == key_down)
        action <= DUCK;
      else
        action <= RUN;
    end
    // over holds everything
  end

endmodule

/* source/hit_detect.sv */
`timescale 1ns/100ps

module hit_detect
  import geometry_pkg::*;
(
  input  logic   frame_clk,
  input  logic   rst_n,
  input  coord_t dragon_y,
  input  logic   duck,
  input  coord_t box_x,
  input  coord_t box_y,
  input  coord_t box_w,
  input  coord_t box_h,
  input  logic   box_off,
  output logic   hit
);

  coord_t right_x;
  coord_t top_y;
  coord_t upper_y;
  coord_t lower_y;
  logic   [3:0] probe_in;

  // half-open box test for one probe point
  function automatic logic in_box(input coord_t px, input coord_t py);
    logic in_x;
    logic in_y;
    in_x = (px >= box_x) && (px < box_x + box_w);
    in_y = (py >= box_y) && (py < box_y + box_h);
    return in_x && in_y;
  endfunction

  always_comb
  begin
    right_x = dragon_x + dragon_w / 2;
    top_y   = dragon_y - dragon_h;
    // ducking lowers the head by half the sprite
    if (duck)
      top_y = top_y + dragon_h / 2;
    upper_y = top_y + dragon_h / 4;
    lower_y = dragon_y - dragon_h / 4;

    probe_in[0] = in_box(right_x, top_y);
    probe_in[1] = in_box(right_x, upper_y);
    probe_in[2] = in_box(dragon_x, top_y);
    probe_in[3] = in_box(dragon_x, lower_y);
  end

  always_ff @(posedge frame_clk or negedge rst_n)
  begin
    if (!rst_n)
      hit <= 1'b0;
    else
      hit <= !box_off && (|probe_in);
  end

endmodule

/* source/dino_control.sv */
`timescale 1ns/100ps

module dino_control
  import game_pkg::*;
  import geometry_pkg::*;
#(
  parameter int ground_level = 412,
  parameter int gravity      = 2,
  parameter int short_jump   = 10,
  parameter int long_jump    = 20,
  parameter int charge_limit = 30
) (
  input  logic        frame_clk,
  input  logic        rst_n,
  input  logic [7:0]  keycode,
  input  coord_t      ptero_x,
  input  coord_t      ptero_y,
  input  coord_t      cactus_x,
  input  coord_t      cactus_y,
  input  coord_t      cactus_w,
  input  coord_t      cactus_h,
  input  logic        ptero_off,
  input  logic        cactus_off,
  output game_state_t state,
  output coord_t      dragon_y,
  output action_t     action,
  output logic        dead
);

  logic duck;
  logic ptero_hit;
  logic cactus_hit;

  game_fsm i_game_fsm (
    .frame_clk (frame_clk),
    .rst_n     (rst_n),
    .keycode   (keycode),
    .dead      (dead),
    .state     (state)
  );

  dragon_motion #(
    .ground_level (ground_level),
    .gravity      (gravity),
    .short_jump   (short_jump),
    .long_jump    (long_jump),
    .charge_limit (charge_limit)
  ) i_dragon_motion (
    .frame_clk (frame_clk),
    .rst_n     (rst_n),
    .keycode   (keycode),
    .state     (state),
    .dead      (dead),
    .dragon_y  (dragon_y),
    .duck      (duck),
    .action    (action)
  );

  // pterosaur size is fixed
  hit_detect i_ptero_hit (
    .frame_clk (frame_clk),
    .rst_n     (rst_n),
    .dragon_y  (dragon_y),
    .duck      (duck),
    .box_x     (ptero_x),
    .box_y     (ptero_y),
    .box_w     (ptero_w),
    .box_h     (ptero_h),
    .box_off   (ptero_off),
    .hit       (ptero_hit)
  );

  hit_detect i_cactus_hit (
    .frame_clk (frame_clk),
    .rst_n     (rst_n),
    .dragon_y  (dragon_y),
    .duck      (duck),
    .box_x     (cactus_x),
    .box_y     (cactus_y),
    .box_w     (cactus_w),
    .box_h     (cactus_h),
    .box_off   (cactus_off),
    .hit       (cactus_hit)
  );

  assign dead = ptero_hit | cactus_hit;

endmodule

/* tests/dino_control_tb.sv */
`timescale 1ns/100ps

module dino_control_tb
  import game_pkg::*;
  import geometry_pkg::*;
();

  localparam int clk_period   = 100;
  localparam int reset_cycles = 8;
  localparam int max_frames   = 512;
  localparam int max_tests    = 32;

  logic        frame_clk;
  logic        rst_n;
  logic [7:0]  keycode;
  coord_t      ptero_x;
  coord_t      ptero_y;
  coord_t      cactus_x;
  coord_t      cactus_y;
  coord_t      cactus_w;
  coord_t      cactus_h;
  logic        ptero_off;
  logic        cactus_off;
  game_state_t state;
  coord_t      dragon_y;
  action_t     action;
  logic        dead;

  // one entry per frame, expanded from the repeat count of each line
  logic [81:0]      stim_mem [max_frames];
  logic             check_mem [max_frames];
  int               exp_state [max_frames];
  int               exp_y [max_frames];
  int               exp_action [max_frames];
  int               exp_dead [max_frames];
  int               test_of [max_frames];
  logic [8*16-1:0]  test_name [max_tests];
  int               test_errs [max_tests];
  int               n_frames;
  int               n_tests;
  int               total_errors;
  int               tests_ok;
  int               tests_bad;
  logic             loaded;

  dino_control i_dino_control (
    .frame_clk  (frame_clk),
    .rst_n      (rst_n),
    .keycode    (keycode),
    .ptero_x    (ptero_x),
    .ptero_y    (ptero_y),
    .cactus_x   (cactus_x),
    .cactus_y   (cactus_y),
    .cactus_w   (cactus_w),
    .cactus_h   (cactus_h),
    .ptero_off  (ptero_off),
    .cactus_off (cactus_off),
    .state      (state),
    .dragon_y   (dragon_y),
    .action     (action),
    .dead       (dead)
  );

  initial
  begin
    frame_clk = 1'b0;
    forever #(clk_period / 2) frame_clk = ~frame_clk;
  end

  task automatic load_frames();
    int fd;
    int count;
    int frames, key, px, py, cx, cy, cw, ch, poff, coff, es, ey, ea, ed;
    logic [8*160-1:0] text;
    logic [8*16-1:0]  name;
    fd = $fopen("tests/dino_control_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file");
      total_errors++;
      return;
    end
    while ($fgets(text, fd) > 0)
    begin
      count = $sscanf(text, "%s %d %h %d %d %d %d %d %d %d %d %d %d %d %d", name, frames,
                      key, px, py, cx, cy, cw, ch, poff, coff, es, ey, ea, ed);
      // comment and blank lines do not parse fully
      if (count == 15)
      begin
        if (n_tests == 0 || name != test_name[n_tests - 1])
        begin
          test_name[n_tests] = name;
          test_errs[n_tests] = 0;
          n_tests++;
        end
        for (int k = 0; k < frames && n_frames < max_frames; k++)
        begin
          stim_mem[n_frames] = {8'(key), 12'(px), 12'(py), 12'(cx), 12'(cy), 12'(cw),
                                12'(ch), 1'(poff), 1'(coff)};
          check_mem[n_frames]  = (k == frames - 1);
          exp_state[n_frames]  = es;
          exp_y[n_frames]      = ey;
          exp_action[n_frames] = ea;
          exp_dead[n_frames]   = ed;
          test_of[n_frames]    = n_tests - 1;
          n_frames++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_frame(input int f);
    {keycode, ptero_x, ptero_y, cactus_x, cactus_y, cactus_w, cactus_h,
     ptero_off, cactus_off} <= stim_mem[f];
  endtask

  task automatic compare_value(input int f, input string what, input int expected,
                               input int actual);
    assert (actual == expected)
    else
    begin
      $display("error %0s %0s expected %0d actual %0d", test_name[test_of[f]], what,
               expected, actual);
      test_errs[test_of[f]]++;
      total_errors++;
    end
  endtask

  task automatic check_frame(input int f);
    compare_value(f, "state", exp_state[f], int'(state));
    compare_value(f, "dragon_y", exp_y[f], int'(dragon_y));
    compare_value(f, "action", exp_action[f], int'(action));
    compare_value(f, "dead", exp_dead[f], int'(dead));
  endtask

  task automatic report_test(input int t);
    if (test_errs[t] == 0)
    begin
      $display("test %0s ok", test_name[t]);
      tests_ok++;
    end
    else
    begin
      $display("test %0s had %0d mismatches", test_name[t], test_errs[t]);
      tests_bad++;
    end
  endtask

  // watchdog sized from the frame count once the file is in
  initial
  begin
    wait (loaded);
    #((n_frames + reset_cycles + 20) * clk_period);
    $display("run timed out before all frames were checked");
    $display("Test failed");
    $finish;
  end

  initial
  begin
    rst_n        = 1'b0;
    keycode      = 8'h00;
    ptero_x      = '0;
    ptero_y      = '0;
    cactus_x     = '0;
    cactus_y     = '0;
    cactus_w     = '0;
    cactus_h     = '0;
    ptero_off    = 1'b0;
    cactus_off   = 1'b0;
    n_frames     = 0;
    n_tests      = 0;
    total_errors = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    loaded       = 1'b0;
    load_frames();
    loaded = 1'b1;

    repeat (reset_cycles) @(posedge frame_clk);
    rst_n <= 1'b1;
    if (n_frames > 0)
      drive_frame(0);

    // outputs of a frame are checked just before the following edge
    for (int f = 0; f < n_frames; f++)
    begin
      @(posedge frame_clk);
      if (f + 1 < n_frames)
        drive_frame(f + 1);
      #(clk_period - 10);
      if (check_mem[f])
        check_frame(f);
      if (f + 1 == n_frames || test_of[f + 1] != test_of[f])
        report_test(test_of[f]);
    end

    $display("%0d tests, %0d ok, %0d with mismatches, %0d mismatches in all",
             n_tests, tests_ok, tests_bad, total_errors);
    if (total_errors == 0 && n_frames > 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* dino_runner.f */
source/game_pkg.sv
source/geometry_pkg.sv
source/game_fsm.sv
source/dragon_motion.sv
source/hit_detect.sv
source/dino_control.sv
tests/dino_control_tb.sv

/* Bender.yml */
package:
  name: dino_runner

sources:
  - source/game_pkg.sv
  - source/geometry_pkg.sv
  - source/game_fsm.sv
  - source/dragon_motion.sv
  - source/hit_detect.sv
  - source/dino_control.sv
  - target: test
    files:
      - tests/dino_control_tb.sv

/* tests/dino_control_input.txt */
# name frames key(hex) ptero_x ptero_y cactus_x cactus_y cactus_w cactus_h ptero_off cactus_off
# then state dragon_y action dead as expected after the last frame of the line
reset       2 00 1000   0 1000   0 40 60 0 0  0 412 0 0
flow        1 20 1000   0 1000   0 40 60 0 0  1 412 0 0
flow        2 00 1000   0 1000   0 40 60 0 0  1 412 0 0
flow        1 0d 1000   0 1000   0 40 60 0 0  0 412 0 0
short_jump  1 20 1000   0 1000   0 40 60 0 0  1 412 0 0
short_jump  5 20 1000   0 1000   0 40 60 0 0  1 412 0 0
short_jump  1 00 1000   0 1000   0 40 60 0 0  1 402 1 0
short_jump  4 00 1000   0 1000   0 40 60 0 0  1 382 1 0
short_jump  5 00 1000   0 1000   0 40 60 0 0  1 402 1 0
short_jump  1 00 1000   0 1000   0 40 60 0 0  1 412 0 0
long_jump  35 20 1000   0 1000   0 40 60 0 0  1 412 0 0
long_jump   1 00 1000   0 1000   0 40 60 0 0  1 392 1 0
long_jump   9 00 1000   0 1000   0 40 60 0 0  1 302 1 0
long_jump  10 00 1000   0 1000   0 40 60 0 0  1 392 1 0
long_jump   1 00 1000   0 1000   0 40 60 0 0  1 412 0 0
duck        1 26 1000   0 1000   0 40 60 0 0  1 412 2 0
duck        3 26  100 262 1000   0 40 60 0 0  1 412 2 0
duck        1 00  100 262 1000   0 40 60 0 0  1 412 0 1
duck        1 00  100 262 1000   0 40 60 0 0  2 412 3 1
duck        1 0d 1000   0 1000   0 40 60 0 0  0 412 3 0
cactus      1 00 1000   0 1000   0 40 60 0 0  0 412 0 0
cactus      1 20 1000   0 1000   0 40 60 0 0  1 412 0 0
cactus      3 20 1000   0 1000   0 40 60 0 0  1 412 0 0
cactus      1 00 1000   0 1000   0 40 60 0 0  1 402 1 0
cactus      2 00 1000   0 1000   0 40 60 0 0  1 388 1 0
cactus      1 00 1000   0  110 350 20 30 0 0  1 384 1 1
cactus      1 00 1000   0  110 350 20 30 0 0  2 382 3 1
cactus      3 00 1000   0  110 350 20 30 0 0  2 382 3 1
cactus      1 0d 1000   0 1000   0 40 60 0 0  0 382 3 0
cactus      1 00 1000   0 1000   0 40 60 0 0  0 412 0 0
disable     1 20 1000   0 1000   0 40 60 0 0  1 412 0 0
disable     2 00  100 262 1000   0 40 60 1 0  1 412 0 0
disable     2 00 1000   0  110 370 20 40 0 1  1 412 0 0
